/* build.f */
src/wb_pkg.sv
src/alu_lanes.sv
src/load_wb_buffer.sv
src/complete_stage.sv
src/phys_regfile.sv
src/rob_complete_tracker.sv
src/wb_top.sv
tests/tb_wb_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_wb_top -o sim_wb
	./obj_dir/sim_wb | tee sim.log
	! grep -q ">>> FAIL" sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_wb_top.sv */
`timescale 1ns/1ps
module tb_wb_top;
    import wb_pkg::*;

    localparam int WB          = 4;
    localparam int LDQ         = 4;
    localparam int NREG        = 128;
    localparam int ROBD        = 64;
    localparam int STIM_CYCLES = 136;
    localparam int LIMIT       = 2 * STIM_CYCLES + ROBD;

    logic                clock_i;
    logic                arst_n_i;
    logic [WB-1:0]       issue_valid_i;
    alu_op_t  [WB-1:0]   issue_op_i;
    word_t    [WB-1:0]   issue_a_i;
    word_t    [WB-1:0]   issue_b_i;
    prf_tag_t [WB-1:0]   issue_dest_i;
    rob_idx_t [WB-1:0]   issue_rob_i;
    logic                ld_valid_i;
    rob_idx_t            ld_rob_i;
    prf_tag_t            ld_dest_i;
    word_t               ld_data_i;
    logic                alloc_i;
    rob_idx_t            alloc_idx_o;
    logic                rob_full_o;
    prf_tag_t            rd_addr_i;
    word_t               rd_data_o;
    logic [WB-1:0]       cdb_valid_o;
    prf_tag_t [WB-1:0]   cdb_tag_o;
    word_t    [WB-1:0]   cdb_value_o;
    logic                commit_valid_o;
    rob_idx_t            commit_rob_o;
    logic                commit_exception_o;
    logic                commit_mispred_o;
    logic                ld_overflow_o;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lfsr_q;
    int          pool[$];
    int          alloc_order[$];
    int          free_tags[$];
    int          ldq_rob[$];
    int          ldq_tag[$];
    word_t       ldq_data[$];
    word_t       prf_model[NREG];
    logic        exp_exc[ROBD];
    logic        exp_mis[ROBD];
    logic        completed[ROBD];
    logic [WB-1:0] last_valid;
    int          last_op[WB];
    word_t       last_a[WB];
    word_t       last_b[WB];
    int          last_dest[WB];
    int          last_rob[WB];
    logic        ovf_exp;
    int          dropped_rob;
    logic        alloc_pend;
    int          alloc_pend_idx;
    int          alloc_count;
    int          ld_cnt_now;
    int          last_cdb_tag;

    wb_top #(.WB_WIDTH(WB), .LDQ_DEPTH(LDQ), .PHYS_REGS(NREG), .ROB_DEPTH(ROBD)) i_wb_top (.*);

    always #50 clock_i = ~clock_i;

    always @(posedge clock_i) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    assert property (@(posedge clock_i) disable iff (!arst_n_i)
        $past(ld_overflow_o) |-> ld_overflow_o)
        else begin
            errors++;
            $display("ld_overflow_o dropped after it was set");
        end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t expected_result(input int op, input word_t a, input word_t b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a ^ b;
            default: return '0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        logic  placed;
        logic  ev;
        int    etag;
        int    erob;
        int    c;
        word_t eval;
        ld_cnt_now = ldq_rob.size();
        placed     = 1'b0;
        check_val("rd_data_o", rd_data_o, prf_model[rd_addr_i]);
        check_val("ld_overflow_o", ld_overflow_o, ovf_exp);
        for (int i = 0; i < WB; i++) begin
            ev   = 1'b0;
            etag = 0;
            erob = 0;
            eval = '0;
            if (last_valid[i]) begin
                ev   = 1'b1;
                etag = last_dest[i];
                erob = last_rob[i];
                eval = expected_result(last_op[i], last_a[i], last_b[i]);
            end else if (ld_cnt_now > 0 && !placed) begin
                // load goes to the lowest idle lane
                ev     = 1'b1;
                placed = 1'b1;
                etag   = ldq_tag[0];
                erob   = ldq_rob[0];
                eval   = ldq_data[0];
            end
            check_val($sformatf("cdb_valid_o[%0d]", i), cdb_valid_o[i], ev);
            if (ev) begin
                check_val($sformatf("cdb_tag_o[%0d]", i), cdb_tag_o[i], etag);
                check_val($sformatf("cdb_value_o[%0d]", i), cdb_value_o[i], eval);
                completed[erob] = 1'b1;
                prf_model[etag] = eval;
                last_cdb_tag    = etag;
                free_tags.push_back(etag);
            end
        end
        if (placed) begin
            void'(ldq_rob.pop_front());
            void'(ldq_tag.pop_front());
            void'(ldq_data.pop_front());
        end
        if (commit_valid_o) begin
            if (alloc_order.size() == 0) begin
                errors++;
                $display("commit seen with no allocated entry outstanding");
            end else begin
                c = alloc_order.pop_front();
                check_val("commit_rob_o", commit_rob_o, c);
                check_val("commit_exception_o", commit_exception_o, exp_exc[c]);
                check_val("commit_mispred_o", commit_mispred_o, exp_mis[c]);
                checks++;
                assert (completed[c]) else begin
                    errors++;
                    $display("ROB entry %0d committed before it completed", c);
                end
            end
        end
        // tail and occupancy include the alloc taken at the last edge
        check_val("alloc_idx_o", alloc_idx_o, (alloc_count + int'(alloc_pend)) % ROBD);
        check_val("rob_full_o", rob_full_o, (alloc_order.size() + int'(alloc_pend)) == ROBD);
    endtask

    // phase 0 sparse, 1 lanes busy with some loads, 2 overflow, 3 drain
    task automatic drive_inputs(input int phase);
        int    rob;
        int    tag;
        int    op;
        logic  busy;
        logic  want_ld;
        word_t a;
        word_t b;
        if (alloc_pend) begin
            pool.push_back(alloc_pend_idx);
            alloc_order.push_back(alloc_pend_idx);
            completed[alloc_pend_idx] = 1'b0;
            alloc_count++;
        end
        alloc_pend     = (phase != 3) && !rob_full_o;
        alloc_i        = alloc_pend;
        alloc_pend_idx = alloc_idx_o;
        busy           = (phase != 0);
        for (int i = 0; i < WB; i++) begin
            last_valid[i]    = 1'b0;
            issue_valid_i[i] = 1'b0;
            if (pool.size() > 0 && (busy || rand_bits(4) == 0)) begin
                rob = pool.pop_front();
                tag = free_tags.pop_front();
                op  = rand_bits(3) % 6;
                a   = rand_bits(32);
                b   = rand_bits(1) ? a : word_t'(rand_bits(32));
                issue_valid_i[i] = 1'b1;
                issue_op_i[i]    = alu_op_t'(op);
                issue_a_i[i]     = a;
                issue_b_i[i]     = b;
                issue_dest_i[i]  = prf_tag_t'(tag);
                issue_rob_i[i]   = rob_idx_t'(rob);
                last_valid[i]    = 1'b1;
                last_op[i]       = op;
                last_a[i]        = a;
                last_b[i]        = b;
                last_dest[i]     = tag;
                last_rob[i]      = rob;
                exp_exc[rob]     = (op == 5);
                exp_mis[rob]     = (op == 4) && (a == b);
            end
        end
        case (phase)
            0:       want_ld = (rand_bits(3) == 0);
            1:       want_ld = (rand_bits(2) == 0);
            2:       want_ld = 1'b1;
            default: want_ld = 1'b0;
        endcase
        ld_valid_i = 1'b0;
        if (want_ld && pool.size() > 0) begin
            rob = pool.pop_front();
            tag = free_tags.pop_front();
            a   = rand_bits(32);
            ld_valid_i   = 1'b1;
            ld_rob_i     = rob_idx_t'(rob);
            ld_dest_i    = prf_tag_t'(tag);
            ld_data_i    = a;
            exp_exc[rob] = 1'b0;
            exp_mis[rob] = 1'b0;
            if (ld_cnt_now == LDQ) begin
                ovf_exp = 1'b1;
                free_tags.push_back(tag);
                if (dropped_rob < 0) begin
                    dropped_rob = rob;
                end
            end else begin
                ldq_rob.push_back(rob);
                ldq_tag.push_back(tag);
                ldq_data.push_back(a);
            end
        end
        rd_addr_i = rand_bits(1) ? prf_tag_t'(last_cdb_tag) : prf_tag_t'(rand_bits(7));
    endtask

    function automatic logic drained();
        return pool.size() == 0 && ldq_rob.size() == 0 && !alloc_pend && last_valid == '0
            && (alloc_order.size() == 0 || alloc_order[0] == dropped_rob);
    endfunction

    initial begin
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        lfsr_q        = 32'h8126;
        clock_i       = 1'b0;
        arst_n_i      = 1'b0;
        issue_valid_i = '0;
        issue_op_i    = '0;
        issue_a_i     = '0;
        issue_b_i     = '0;
        issue_dest_i  = '0;
        issue_rob_i   = '0;
        ld_valid_i    = 1'b0;
        ld_rob_i      = '0;
        ld_dest_i     = '0;
        ld_data_i     = '0;
        alloc_i       = 1'b0;
        rd_addr_i     = '0;
        last_valid    = '0;
        ovf_exp       = 1'b0;
        dropped_rob   = -1;
        alloc_pend    = 1'b0;
        alloc_count   = 0;
        last_cdb_tag  = 0;
        for (int t = 0; t < NREG; t++) begin
            free_tags.push_back(t);
            prf_model[t] = '0;
        end
        for (int r = 0; r < ROBD; r++) begin
            completed[r] = 1'b0;
        end
        repeat (5) begin
            @(negedge clock_i);
            check_val("cdb_valid_o", cdb_valid_o, '0);
            check_val("commit_valid_o", commit_valid_o, 1'b0);
            check_val("ld_overflow_o", ld_overflow_o, 1'b0);
        end
        arst_n_i = 1'b1;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(negedge clock_i);
            check_outputs();
            drive_inputs(c < 60 ? 0 : c < 68 ? 1 : c < 128 ? 0 : 2);
        end
        while (!drained()) begin
            @(negedge clock_i);
            check_outputs();
            drive_inputs(3);
        end
        repeat (3) begin
            @(negedge clock_i);
            check_outputs();
            drive_inputs(3);
        end
        if (!ovf_exp) begin
            errors++;
            $display("overflow phase never filled the load buffer");
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* src/wb_top.sv */
`timescale 1ns/1ps
module wb_top #(
    parameter int unsigned WB_WIDTH  = wb_pkg::WB_WIDTH_DEF,
    parameter int unsigned LDQ_DEPTH = wb_pkg::LDQ_DEPTH_DEF,
    parameter int unsigned PHYS_REGS = wb_pkg::PHYS_REGS_DEF,
    parameter int unsigned ROB_DEPTH = wb_pkg::ROB_DEPTH_DEF
) (
    input  logic                            clock_i,
    input  logic                            arst_n_i,
    input  logic [WB_WIDTH-1:0]             issue_valid_i,
    input  wb_pkg::alu_op_t  [WB_WIDTH-1:0] issue_op_i,
    input  wb_pkg::word_t    [WB_WIDTH-1:0] issue_a_i,
    input  wb_pkg::word_t    [WB_WIDTH-1:0] issue_b_i,
    input  wb_pkg::prf_tag_t [WB_WIDTH-1:0] issue_dest_i,
    input  wb_pkg::rob_idx_t [WB_WIDTH-1:0] issue_rob_i,
    input  logic                            ld_valid_i,
    input  wb_pkg::rob_idx_t                ld_rob_i,
    input  wb_pkg::prf_tag_t                ld_dest_i,
    input  wb_pkg::word_t                   ld_data_i,
    input  logic                            alloc_i,
    output wb_pkg::rob_idx_t                alloc_idx_o,
    output logic                            rob_full_o,
    input  wb_pkg::prf_tag_t                rd_addr_i,
    output wb_pkg::word_t                   rd_data_o,
    output logic [WB_WIDTH-1:0]             cdb_valid_o,
    output wb_pkg::prf_tag_t [WB_WIDTH-1:0] cdb_tag_o,
    output wb_pkg::word_t    [WB_WIDTH-1:0] cdb_value_o,
    output logic                            commit_valid_o,
    output wb_pkg::rob_idx_t                commit_rob_o,
    output logic                            commit_exception_o,
    output logic                            commit_mispred_o,
    output logic                            ld_overflow_o
);
    import wb_pkg::*;

    logic     [WB_WIDTH-1:0] fu_valid;
    word_t    [WB_WIDTH-1:0] fu_value;
    prf_tag_t [WB_WIDTH-1:0] fu_dest;
    rob_idx_t [WB_WIDTH-1:0] fu_rob;
    logic     [WB_WIDTH-1:0] fu_exception;
    logic     [WB_WIDTH-1:0] fu_mispred;
    logic                    head_valid;
    rob_idx_t                head_rob;
    prf_tag_t                head_dest;
    word_t                   head_data;
    logic                    ld_pop;
    logic     [WB_WIDTH-1:0] prf_wr_en;
    prf_tag_t [WB_WIDTH-1:0] prf_waddr;
    word_t    [WB_WIDTH-1:0] prf_wdata;
    logic     [WB_WIDTH-1:0] wb_valid;
    rob_idx_t [WB_WIDTH-1:0] wb_rob;
    logic     [WB_WIDTH-1:0] wb_exception;
    logic     [WB_WIDTH-1:0] wb_mispred;

    alu_lanes #(.WB_WIDTH(WB_WIDTH)) i_alu_lanes (
        .clock_i, .arst_n_i,
        .issue_valid_i, .issue_op_i, .issue_a_i, .issue_b_i, .issue_dest_i, .issue_rob_i,
        .fu_valid_o(fu_valid), .fu_value_o(fu_value), .fu_dest_o(fu_dest),
        .fu_rob_o(fu_rob), .fu_exception_o(fu_exception), .fu_mispred_o(fu_mispred)
    );

    load_wb_buffer #(.LDQ_DEPTH(LDQ_DEPTH)) i_load_wb_buffer (
        .clock_i, .arst_n_i,
        .ld_valid_i, .ld_rob_i, .ld_dest_i, .ld_data_i,
        .ld_pop_i(ld_pop),
        .head_valid_o(head_valid), .head_rob_o(head_rob),
        .head_dest_o(head_dest), .head_data_o(head_data),
        .ld_overflow_o
    );

    complete_stage #(.WB_WIDTH(WB_WIDTH)) i_complete_stage (
        .clock_i, .arst_n_i,
        .fu_valid_i(fu_valid), .fu_value_i(fu_value), .fu_dest_i(fu_dest),
        .fu_rob_i(fu_rob), .fu_exception_i(fu_exception), .fu_mispred_i(fu_mispred),
        .head_valid_i(head_valid), .head_rob_i(head_rob),
        .head_dest_i(head_dest), .head_data_i(head_data), .ld_pop_o(ld_pop),
        .prf_wr_en_o(prf_wr_en), .prf_waddr_o(prf_waddr), .prf_wdata_o(prf_wdata),
        .wb_valid_o(wb_valid), .wb_rob_o(wb_rob),
        .wb_exception_o(wb_exception), .wb_mispred_o(wb_mispred),
        .cdb_valid_o, .cdb_tag_o, .cdb_value_o
    );

    phys_regfile #(.WB_WIDTH(WB_WIDTH), .PHYS_REGS(PHYS_REGS)) i_phys_regfile (
        .clock_i, .arst_n_i,
        .prf_wr_en_i(prf_wr_en), .prf_waddr_i(prf_waddr), .prf_wdata_i(prf_wdata),
        .rd_addr_i, .rd_data_o
    );

    rob_complete_tracker #(.WB_WIDTH(WB_WIDTH), .ROB_DEPTH(ROB_DEPTH)) i_rob_tracker (
        .clock_i, .arst_n_i,
        .alloc_i, .alloc_idx_o, .rob_full_o,
        .wb_valid_i(wb_valid), .wb_rob_i(wb_rob),
        .wb_exception_i(wb_exception), .wb_mispred_i(wb_mispred),
        .commit_valid_o, .commit_rob_o, .commit_exception_o, .commit_mispred_o
    );

endmodule

/* src/rob_complete_tracker.sv */
`timescale 1ns/1ps
module rob_complete_tracker #(
    parameter int unsigned WB_WIDTH  = wb_pkg::WB_WIDTH_DEF,
    parameter int unsigned ROB_DEPTH = wb_pkg::ROB_DEPTH_DEF
) (
    input  logic                            clock_i,
    input  logic                            arst_n_i,
    input  logic                            alloc_i,
    output wb_pkg::rob_idx_t                alloc_idx_o,
    output logic                            rob_full_o,
    input  logic [WB_WIDTH-1:0]             wb_valid_i,
    input  wb_pkg::rob_idx_t [WB_WIDTH-1:0] wb_rob_i,
    input  logic [WB_WIDTH-1:0]             wb_exception_i,
    input  logic [WB_WIDTH-1:0]             wb_mispred_i,
    output logic                            commit_valid_o,
    output wb_pkg::rob_idx_t                commit_rob_o,
    output logic                            commit_exception_o,
    output logic                            commit_mispred_o
);
    import wb_pkg::*;

    localparam int unsigned IDX_W = $clog2(ROB_DEPTH);

    logic [ROB_DEPTH-1:0] alloc_q;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] exc_q;
    logic [ROB_DEPTH-1:0] mis_q;
    logic [IDX_W:0]       head_q;
    logic [IDX_W:0]       tail_q;
    logic [IDX_W-1:0]     head_idx;
    logic [IDX_W-1:0]     tail_idx;
    logic                 do_alloc;
    logic                 do_commit;
    logic [WB_WIDTH-1:0]  wb_stray;

    assign head_idx    = head_q[IDX_W-1:0];
    assign tail_idx    = tail_q[IDX_W-1:0];
    // same index, different lap
    assign rob_full_o  = (head_q[IDX_W] != tail_q[IDX_W]) && (head_idx == tail_idx);
    assign alloc_idx_o = rob_idx_t'(tail_idx);
    assign do_alloc    = alloc_i && !rob_full_o;
    assign do_commit   = alloc_q[head_idx] && done_q[head_idx];

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alloc_q        <= '0;
            done_q         <= '0;
            head_q         <= '0;
            tail_q         <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= do_commit;
            for (int i = 0; i < WB_WIDTH; i++) begin
                if (wb_valid_i[i]) begin
                    done_q[wb_rob_i[i]] <= 1'b1;
                end
            end
            if (do_commit) begin
                alloc_q[head_idx] <= 1'b0;
                head_q            <= head_q + 1'b1;
            end
            if (do_alloc) begin
                alloc_q[tail_idx] <= 1'b1;
                done_q[tail_idx]  <= 1'b0;
                tail_q            <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (wb_valid_i[i]) begin
                exc_q[wb_rob_i[i]] <= wb_exception_i[i];
                mis_q[wb_rob_i[i]] <= wb_mispred_i[i];
            end
        end
        if (do_commit) begin
            commit_rob_o       <= rob_idx_t'(head_idx);
            commit_exception_o <= exc_q[head_idx];
            commit_mispred_o   <= mis_q[head_idx];
        end
    end

    always_comb begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            wb_stray[i] = wb_valid_i[i] && !alloc_q[wb_rob_i[i]];
        end
    end

    assert property (@(posedge clock_i) disable iff (!arst_n_i) wb_stray == '0);

endmodule

/* src/phys_regfile.sv */
`timescale 1ns/1ps
module phys_regfile #(
    parameter int unsigned WB_WIDTH  = wb_pkg::WB_WIDTH_DEF,
    parameter int unsigned PHYS_REGS = wb_pkg::PHYS_REGS_DEF
) (
    input  logic                            clock_i,
    input  logic                            arst_n_i,
    input  logic [WB_WIDTH-1:0]             prf_wr_en_i,
    input  wb_pkg::prf_tag_t [WB_WIDTH-1:0] prf_waddr_i,
    input  wb_pkg::word_t    [WB_WIDTH-1:0] prf_wdata_i,
    input  wb_pkg::prf_tag_t                rd_addr_i,
    output wb_pkg::word_t                   rd_data_o
);
    import wb_pkg::*;

    word_t regs_q [PHYS_REGS];
    logic  collide;

    // later lanes overwrite earlier ones on a shared address
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < PHYS_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int i = 0; i < WB_WIDTH; i++) begin
                if (prf_wr_en_i[i]) begin
                    regs_q[prf_waddr_i[i]] <= prf_wdata_i[i];
                end
            end
        end
    end

    assign rd_data_o = regs_q[rd_addr_i];

    always_comb begin
        collide = 1'b0;
        for (int i = 0; i < WB_WIDTH; i++) begin
            for (int j = i + 1; j < WB_WIDTH; j++) begin
                if (prf_wr_en_i[i] && prf_wr_en_i[j] && prf_waddr_i[i] == prf_waddr_i[j]) begin
                    collide = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clock_i) disable iff (!arst_n_i) !collide);

endmodule

/* src/complete_stage.sv */
`timescale 1ns/1ps
module complete_stage #(
    parameter int unsigned WB_WIDTH = wb_pkg::WB_WIDTH_DEF
) (
    input  logic                            clock_i,
    input  logic                            arst_n_i,
    input  logic [WB_WIDTH-1:0]             fu_valid_i,
    input  wb_pkg::word_t    [WB_WIDTH-1:0] fu_value_i,
    input  wb_pkg::prf_tag_t [WB_WIDTH-1:0] fu_dest_i,
    input  wb_pkg::rob_idx_t [WB_WIDTH-1:0] fu_rob_i,
    input  logic [WB_WIDTH-1:0]             fu_exception_i,
    input  logic [WB_WIDTH-1:0]             fu_mispred_i,
    input  logic                            head_valid_i,
    input  wb_pkg::rob_idx_t                head_rob_i,
    input  wb_pkg::prf_tag_t                head_dest_i,
    input  wb_pkg::word_t                   head_data_i,
    output logic                            ld_pop_o,
    output logic [WB_WIDTH-1:0]             prf_wr_en_o,
    output wb_pkg::prf_tag_t [WB_WIDTH-1:0] prf_waddr_o,
    output wb_pkg::word_t    [WB_WIDTH-1:0] prf_wdata_o,
    output logic [WB_WIDTH-1:0]             wb_valid_o,
    output wb_pkg::rob_idx_t [WB_WIDTH-1:0] wb_rob_o,
    output logic [WB_WIDTH-1:0]             wb_exception_o,
    output logic [WB_WIDTH-1:0]             wb_mispred_o,
    output logic [WB_WIDTH-1:0]             cdb_valid_o,
    output wb_pkg::prf_tag_t [WB_WIDTH-1:0] cdb_tag_o,
    output wb_pkg::word_t    [WB_WIDTH-1:0] cdb_value_o
);

    logic [WB_WIDTH-1:0] idle;
    logic [WB_WIDTH-1:0] sel_load;
    logic                dup_rob;

    // lowest idle lane takes the buffered load
    assign idle     = ~fu_valid_i;
    assign sel_load = head_valid_i ? (idle & (~idle + 1'b1)) : '0;
    assign ld_pop_o = |(wb_valid_o & idle);

    always_comb begin
        prf_wr_en_o    = '0;
        prf_waddr_o    = '0;
        prf_wdata_o    = '0;
        wb_valid_o     = '0;
        wb_rob_o       = '0;
        wb_exception_o = '0;
        wb_mispred_o   = '0;
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (fu_valid_i[i]) begin
                prf_wr_en_o[i]    = 1'b1;
                prf_waddr_o[i]    = fu_dest_i[i];
                prf_wdata_o[i]    = fu_value_i[i];
                wb_valid_o[i]     = 1'b1;
                wb_rob_o[i]       = fu_rob_i[i];
                wb_exception_o[i] = fu_exception_i[i];
                wb_mispred_o[i]   = fu_mispred_i[i];
            end else if (sel_load[i]) begin
                // loads complete with clean flags
                prf_wr_en_o[i] = 1'b1;
                prf_waddr_o[i] = head_dest_i;
                prf_wdata_o[i] = head_data_i;
                wb_valid_o[i]  = 1'b1;
                wb_rob_o[i]    = head_rob_i;
            end
        end
    end

    assign cdb_valid_o = prf_wr_en_o;
    assign cdb_tag_o   = prf_waddr_o;
    assign cdb_value_o = prf_wdata_o;

    always_comb begin
        dup_rob = 1'b0;
        for (int i = 0; i < WB_WIDTH; i++) begin
            for (int j = i + 1; j < WB_WIDTH; j++) begin
                if (wb_valid_o[i] && wb_valid_o[j] && wb_rob_o[i] == wb_rob_o[j]) begin
                    dup_rob = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clock_i) disable iff (!arst_n_i) !dup_rob);
    assert property (@(posedge clock_i) disable iff (!arst_n_i)
        ld_pop_o |-> head_valid_i);

endmodule

/* src/load_wb_buffer.sv */
`timescale 1ns/1ps
module load_wb_buffer #(
    parameter int unsigned LDQ_DEPTH = wb_pkg::LDQ_DEPTH_DEF
) (
    input  logic             clock_i,
    input  logic             arst_n_i,
    input  logic             ld_valid_i,
    input  wb_pkg::rob_idx_t ld_rob_i,
    input  wb_pkg::prf_tag_t ld_dest_i,
    input  wb_pkg::word_t    ld_data_i,
    input  logic             ld_pop_i,
    output logic             head_valid_o,
    output wb_pkg::rob_idx_t head_rob_o,
    output wb_pkg::prf_tag_t head_dest_o,
    output wb_pkg::word_t    head_data_o,
    output logic             ld_overflow_o
);
    import wb_pkg::*;

    localparam int unsigned PTR_W = (LDQ_DEPTH > 1) ? $clog2(LDQ_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(LDQ_DEPTH + 1);

    rob_idx_t         mem_rob  [LDQ_DEPTH];
    prf_tag_t         mem_dest [LDQ_DEPTH];
    word_t            mem_data [LDQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count_q == CNT_W'(LDQ_DEPTH));
    // a push into a full buffer is lost
    assign push = ld_valid_i && !full;
    assign pop  = ld_pop_i && head_valid_o;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            ld_overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(LDQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(LDQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
            if (ld_valid_i && full) begin
                ld_overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (push) begin
            mem_rob[wr_ptr_q]  <= ld_rob_i;
            mem_dest[wr_ptr_q] <= ld_dest_i;
            mem_data[wr_ptr_q] <= ld_data_i;
        end
    end

    assign head_valid_o = (count_q != '0);
    assign head_rob_o   = mem_rob[rd_ptr_q];
    assign head_dest_o  = mem_dest[rd_ptr_q];
    assign head_data_o  = mem_data[rd_ptr_q];

    assert property (@(posedge clock_i) disable iff (!arst_n_i)
        ld_pop_i |-> count_q != '0);
    assert property (@(posedge clock_i) disable iff (!arst_n_i)
        count_q <= CNT_W'(LDQ_DEPTH));

endmodule

/* src/alu_lanes.sv */
`timescale 1ns/1ps
module alu_lanes #(
    parameter int unsigned WB_WIDTH = wb_pkg::WB_WIDTH_DEF
) (
    input  logic                                clock_i,
    input  logic                                arst_n_i,
    input  logic [WB_WIDTH-1:0]                 issue_valid_i,
    input  wb_pkg::alu_op_t  [WB_WIDTH-1:0]     issue_op_i,
    input  wb_pkg::word_t    [WB_WIDTH-1:0]     issue_a_i,
    input  wb_pkg::word_t    [WB_WIDTH-1:0]     issue_b_i,
    input  wb_pkg::prf_tag_t [WB_WIDTH-1:0]     issue_dest_i,
    input  wb_pkg::rob_idx_t [WB_WIDTH-1:0]     issue_rob_i,
    output logic [WB_WIDTH-1:0]                 fu_valid_o,
    output wb_pkg::word_t    [WB_WIDTH-1:0]     fu_value_o,
    output wb_pkg::prf_tag_t [WB_WIDTH-1:0]     fu_dest_o,
    output wb_pkg::rob_idx_t [WB_WIDTH-1:0]     fu_rob_o,
    output logic [WB_WIDTH-1:0]                 fu_exception_o,
    output logic [WB_WIDTH-1:0]                 fu_mispred_o
);
    import wb_pkg::*;

    word_t [WB_WIDTH-1:0] value_d;
    logic  [WB_WIDTH-1:0] exc_d;
    logic  [WB_WIDTH-1:0] mis_d;

    always_comb begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            value_d[i] = '0;
            exc_d[i]   = 1'b0;
            mis_d[i]   = 1'b0;
            case (issue_op_i[i])
                OP_ADD:  value_d[i] = issue_a_i[i] + issue_b_i[i];
                OP_SUB:  value_d[i] = issue_a_i[i] - issue_b_i[i];
                OP_AND:  value_d[i] = issue_a_i[i] & issue_b_i[i];
                OP_XOR:  value_d[i] = issue_a_i[i] ^ issue_b_i[i];
                OP_BEQ:  mis_d[i]   = (issue_a_i[i] == issue_b_i[i]);
                default: exc_d[i]   = 1'b1;
            endcase
            // flags only mean something on a live lane
            exc_d[i] = exc_d[i] & issue_valid_i[i];
            mis_d[i] = mis_d[i] & issue_valid_i[i];
        end
    end

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fu_valid_o     <= '0;
            fu_exception_o <= '0;
            fu_mispred_o   <= '0;
        end else begin
            fu_valid_o     <= issue_valid_i;
            fu_exception_o <= exc_d;
            fu_mispred_o   <= mis_d;
        end
    end

    always_ff @(posedge clock_i) begin
        fu_value_o <= value_d;
        fu_dest_o  <= issue_dest_i;
        fu_rob_o   <= issue_rob_i;
    end

    assert property (@(posedge clock_i) disable iff (!arst_n_i)
        ((fu_exception_o | fu_mispred_o) & ~fu_valid_o) == '0);

endmodule

/* src/wb_pkg.sv */
package wb_pkg;

    localparam int unsigned XLEN_W        = 32;
    localparam int unsigned WB_WIDTH_DEF  = 4;
    localparam int unsigned LDQ_DEPTH_DEF = 4;
    localparam int unsigned PHYS_REGS_DEF = 128;
    localparam int unsigned ROB_DEPTH_DEF = 64;

    typedef logic [$clog2(PHYS_REGS_DEF)-1:0] prf_tag_t;
    typedef logic [$clog2(ROB_DEPTH_DEF)-1:0] rob_idx_t;
    typedef logic [XLEN_W-1:0]                word_t;

    // predictor is static not-taken, so an equal BEQ is a mispredict
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_BEQ = 3'd4,
        OP_ILL = 3'd5
    } alu_op_t;

endpackage
